// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_softcore_uncore
FILELIST = softcore_uncore.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module cfg_regs
  (input  wire                     clk_i
   , input  wire                   arst_n_i

   , input  softcore_pkg::mem_msg_s cmd_i
   , input  wire                   cmd_v_i
   , output logic                  cmd_ready_o

   , output softcore_pkg::mem_msg_s resp_o
   , output logic                  resp_v_o
   , input  wire                   resp_ready_i
   );

  softcore_pkg::dword_t regs_r [softcore_pkg::cfg_regs_lp];
  softcore_pkg::mem_msg_s resp_r;
  logic resp_v_r;

  softcore_pkg::cfg_sel_t sel;
  logic accept;
  logic is_wr;

  assign sel    = cmd_i.addr[softcore_pkg::cfg_sel_lsb_lp +: softcore_pkg::cfg_sel_width_lp];
  assign is_wr  = (cmd_i.msg_type == softcore_pkg::e_mem_wr);
  // One outstanding response at a time
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & ~resp_v_r;

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < softcore_pkg::cfg_regs_lp; i++)
        regs_r[i] <= '0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (accept && is_wr)
        regs_r[sel] <= cmd_i.data;
      if (accept)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r          <= cmd_i;
      resp_r.data     <= is_wr ? '0 : regs_r[sel];
    end
  end

endmodule

`default_nettype wire

// ==== clint_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint_slice
  (input  wire                     clk_i
   , input  wire                   arst_n_i

   , input  softcore_pkg::mem_msg_s cmd_i
   , input  wire                   cmd_v_i
   , output logic                  cmd_ready_o

   , output softcore_pkg::mem_msg_s resp_o
   , output logic                  resp_v_o
   , input  wire                   resp_ready_i

   , output logic                  timer_irq_o
   , output logic                  software_irq_o
   );

  softcore_pkg::dword_t mtime_r;
  softcore_pkg::dword_t mtimecmp_r;
  logic msip_r;
  logic timer_irq_r;

  softcore_pkg::mem_msg_s resp_r;
  logic resp_v_r;

  softcore_pkg::clint_offset_t offset;
  logic accept;
  logic is_wr;
  softcore_pkg::dword_t rd_data;

  assign offset = cmd_i.addr[$bits(softcore_pkg::clint_offset_t)-1:0];
  assign is_wr  = (cmd_i.msg_type == softcore_pkg::e_mem_wr);
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & ~resp_v_r;

  always_comb
  begin
    case (offset)
      softcore_pkg::clint_msip_lp:     rd_data = {{63{1'b0}}, msip_r};
      softcore_pkg::clint_mtimecmp_lp: rd_data = mtimecmp_r;
      softcore_pkg::clint_mtime_lp:    rd_data = mtime_r;
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
      resp_v_r    <= 1'b0;
    end
    else
    begin
      // mtime is free running and ignores writes
      mtime_r     <= mtime_r + 64'd1;
      timer_irq_r <= (mtime_r >= mtimecmp_r);
      if (accept && is_wr && (offset == softcore_pkg::clint_msip_lp))
        msip_r <= cmd_i.data[0];
      if (accept && is_wr && (offset == softcore_pkg::clint_mtimecmp_lp))
        mtimecmp_r <= cmd_i.data;
      if (accept)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r      <= cmd_i;
      resp_r.data <= is_wr ? '0 : rd_data;
    end
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

`default_nettype wire

// ==== cmd_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_router
  (input  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] head_i
   , input  wire [softcore_pkg::num_src_lp-1:0]                  head_v_i
   , output logic [softcore_pkg::num_src_lp-1:0]                 head_pop_o

   , output softcore_pkg::mem_msg_s                              cmd_o

   , output logic                                                cfg_v_o
   , input  wire                                                 cfg_ready_i
   , output logic                                                clint_v_o
   , input  wire                                                 clint_ready_i
   , output logic                                                io_v_o
   , input  wire                                                 io_ready_i
   , output logic                                                mem_v_o
   , input  wire                                                 mem_ready_i
   );

  logic [softcore_pkg::num_src_lp-1:0] grant;
  logic all_ready;
  logic granted;

  logic                  is_local;
  softcore_pkg::dev_id_t dev_id;
  logic                  is_cfg, is_clint, is_io;

  // Conservative: a single busy target stalls every source
  assign all_ready = cfg_ready_i & clint_ready_i & io_ready_i & mem_ready_i;

  // Fixed priority, highest index wins
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < softcore_pkg::num_src_lp; i++)
    begin
      if (head_v_i[i])
      begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
    if (!all_ready)
      grant = '0;
  end

  assign head_pop_o = grant;
  assign granted    = |grant;

  always_comb
  begin
    cmd_o = '0;
    for (int i = 0; i < softcore_pkg::num_src_lp; i++)
    begin
      if (grant[i])
        cmd_o = head_i[i];
    end
  end

  // Local address map
  assign is_local = (cmd_o.addr < softcore_pkg::dram_base_lp);
  assign dev_id   = cmd_o.addr[softcore_pkg::dev_lsb_lp +: softcore_pkg::dev_id_width_lp];
  assign is_cfg   = is_local & (dev_id == softcore_pkg::cfg_dev_lp);
  assign is_clint = is_local & (dev_id == softcore_pkg::clint_dev_lp);
  assign is_io    = is_local & (dev_id == softcore_pkg::host_dev_lp);

  assign cfg_v_o   = granted & is_cfg;
  assign clint_v_o = granted & is_clint;
  assign io_v_o    = granted & is_io;
  // Unknown local devices fall through to memory
  assign mem_v_o   = granted & ~(is_cfg | is_clint | is_io);

endmodule

`default_nettype wire

// ==== mem_two_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_two_fifo
  (input  wire                    clk_i
   , input  wire                  arst_n_i

   , input  softcore_pkg::mem_msg_s data_i
   , input  wire                  v_i
   , output logic                 ready_o

   , output softcore_pkg::mem_msg_s data_o
   , output logic                 v_o
   , input  wire                  ready_i
   );

  softcore_pkg::mem_msg_s mem_r [2];

  logic wr_ptr_r, rd_ptr_r;
  logic full_r, empty_r;
  logic enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ~full_r;
  assign deq = ready_i & ~empty_r;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // Occupancy only moves when exactly one side fires
      if (enq && !deq)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);
      end
      else if (deq && !enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

endmodule

`default_nettype wire

// ==== resp_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module resp_router
  (input  softcore_pkg::mem_msg_s                mem_resp_i
   , input  wire                                 mem_resp_v_i
   , output logic                                mem_ready_o
   , input  softcore_pkg::mem_msg_s              io_resp_i
   , input  wire                                 io_resp_v_i
   , output logic                                io_ready_o
   , input  softcore_pkg::mem_msg_s              clint_resp_i
   , input  wire                                 clint_resp_v_i
   , output logic                                clint_ready_o
   , input  softcore_pkg::mem_msg_s              cfg_resp_i
   , input  wire                                 cfg_resp_v_i
   , output logic                                cfg_ready_o

   , output softcore_pkg::mem_msg_s              resp_o
   , output logic [softcore_pkg::num_src_lp-1:0] resp_v_o
   , input  wire  [softcore_pkg::num_src_lp-1:0] fifo_ready_i
   );

  logic all_ready;
  logic granted;

  assign all_ready = &fifo_ready_i;

  // Memory first, then host I/O, CLINT, config
  assign mem_ready_o   = all_ready & mem_resp_v_i;
  assign io_ready_o    = all_ready & ~mem_resp_v_i & io_resp_v_i;
  assign clint_ready_o = all_ready & ~mem_resp_v_i & ~io_resp_v_i & clint_resp_v_i;
  assign cfg_ready_o   = all_ready & ~mem_resp_v_i & ~io_resp_v_i & ~clint_resp_v_i
                         & cfg_resp_v_i;

  assign granted = mem_ready_o | io_ready_o | clint_ready_o | cfg_ready_o;

  always_comb
  begin
    if (mem_ready_o)
      resp_o = mem_resp_i;
    else if (io_ready_o)
      resp_o = io_resp_i;
    else if (clint_ready_o)
      resp_o = clint_resp_i;
    else
      resp_o = cfg_resp_i;
  end

  // Steer by the id of the issuing source
  always_comb
  begin
    for (int i = 0; i < softcore_pkg::num_src_lp; i++)
      resp_v_o[i] = granted & (resp_o.lce_id == softcore_pkg::lce_id_t'(i));
  end

endmodule

`default_nettype wire

// ==== softcore_pkg.sv ====
`default_nettype none

package softcore_pkg;

  localparam int num_src_lp = 3;

  localparam int paddr_width_lp = 40;
  localparam int dword_width_lp = 64;
  localparam int lce_id_width_lp = 2;
  localparam int dev_id_width_lp = 4;

  // Device field position inside a local address
  localparam int dev_lsb_lp = 20;

  typedef logic [paddr_width_lp-1:0]  paddr_t;
  typedef logic [dword_width_lp-1:0]  dword_t;
  typedef logic [lce_id_width_lp-1:0] lce_id_t;
  typedef logic [dev_id_width_lp-1:0] dev_id_t;

  typedef enum logic
  {
    e_mem_rd = 1'b0
    ,e_mem_wr = 1'b1
  } mem_msg_e;

  // Shared by commands and responses
  typedef struct packed
  {
    mem_msg_e msg_type;
    paddr_t   addr;
    lce_id_t  lce_id;
    dword_t   data;
  } mem_msg_s;

  // Everything at or above this address is main memory
  localparam paddr_t dram_base_lp = 40'h80_0000_0000;

  localparam dev_id_t host_dev_lp  = 4'd1;
  localparam dev_id_t cfg_dev_lp   = 4'd2;
  localparam dev_id_t clint_dev_lp = 4'd3;

  localparam int cfg_regs_lp = 4;
  localparam int cfg_sel_lsb_lp = 3;
  localparam int cfg_sel_width_lp = $clog2(cfg_regs_lp);
  typedef logic [cfg_sel_width_lp-1:0] cfg_sel_t;

  // CLINT register offsets, low 16 address bits
  typedef logic [15:0] clint_offset_t;
  localparam clint_offset_t clint_msip_lp     = 16'h0000;
  localparam clint_offset_t clint_mtimecmp_lp = 16'h4000;
  localparam clint_offset_t clint_mtime_lp    = 16'hbff8;

endpackage

`default_nettype wire

// ==== softcore_uncore.f ====
softcore_pkg.sv
mem_two_fifo.sv
cmd_router.sv
resp_router.sv
cfg_regs.sv
clint_slice.sv
softcore_uncore.sv
tb_softcore_uncore_assertions.sv
tb_softcore_uncore.sv

// ==== softcore_uncore.sv ====
`timescale 1ns/1ns
`default_nettype none

module softcore_uncore
  (input  wire                                                    clk_i
   , input  wire                                                  arst_n_i

   // Command sources: icache engine, dcache engine, incoming host I/O
   , input  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] proc_cmd_i
   , input  wire  [softcore_pkg::num_src_lp-1:0]                  proc_cmd_v_i
   , output logic [softcore_pkg::num_src_lp-1:0]                  proc_cmd_ready_o

   , output softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] proc_resp_o
   , output logic [softcore_pkg::num_src_lp-1:0]                  proc_resp_v_o
   , input  wire  [softcore_pkg::num_src_lp-1:0]                  proc_resp_ready_i

   // Outgoing I/O
   , output softcore_pkg::mem_msg_s                               io_cmd_o
   , output logic                                                 io_cmd_v_o
   , input  wire                                                  io_cmd_ready_i
   , input  softcore_pkg::mem_msg_s                               io_resp_i
   , input  wire                                                  io_resp_v_i
   , output logic                                                 io_resp_ready_o

   // Main memory
   , output softcore_pkg::mem_msg_s                               mem_cmd_o
   , output logic                                                 mem_cmd_v_o
   , input  wire                                                  mem_cmd_ready_i
   , input  softcore_pkg::mem_msg_s                               mem_resp_i
   , input  wire                                                  mem_resp_v_i
   , output logic                                                 mem_resp_ready_o

   , output logic                                                 timer_irq_o
   , output logic                                                 software_irq_o
   );

  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] cmd_head;
  logic [softcore_pkg::num_src_lp-1:0] cmd_head_v, cmd_pop;

  softcore_pkg::mem_msg_s routed_cmd;
  logic cfg_cmd_v, cfg_cmd_ready;
  logic clint_cmd_v, clint_cmd_ready;

  softcore_pkg::mem_msg_s cfg_resp, clint_resp;
  logic cfg_resp_v, cfg_resp_ready;
  logic clint_resp_v, clint_resp_ready;

  softcore_pkg::mem_msg_s routed_resp;
  logic [softcore_pkg::num_src_lp-1:0] resp_fifo_v, resp_fifo_ready;

  for (genvar i = 0; i < softcore_pkg::num_src_lp; i++)
  begin : fifo
    mem_two_fifo cmd_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(proc_cmd_i[i])
       ,.v_i(proc_cmd_v_i[i])
       ,.ready_o(proc_cmd_ready_o[i])
       ,.data_o(cmd_head[i])
       ,.v_o(cmd_head_v[i])
       ,.ready_i(cmd_pop[i])
       );

    mem_two_fifo resp_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(routed_resp)
       ,.v_i(resp_fifo_v[i])
       ,.ready_o(resp_fifo_ready[i])
       ,.data_o(proc_resp_o[i])
       ,.v_o(proc_resp_v_o[i])
       ,.ready_i(proc_resp_ready_i[i])
       );
  end

  cmd_router cmd_router_i
    (.head_i(cmd_head)
     ,.head_v_i(cmd_head_v)
     ,.head_pop_o(cmd_pop)
     ,.cmd_o(routed_cmd)
     ,.cfg_v_o(cfg_cmd_v)
     ,.cfg_ready_i(cfg_cmd_ready)
     ,.clint_v_o(clint_cmd_v)
     ,.clint_ready_i(clint_cmd_ready)
     ,.io_v_o(io_cmd_v_o)
     ,.io_ready_i(io_cmd_ready_i)
     ,.mem_v_o(mem_cmd_v_o)
     ,.mem_ready_i(mem_cmd_ready_i)
     );

  // No L2 slice, memory commands go straight out
  assign io_cmd_o  = routed_cmd;
  assign mem_cmd_o = routed_cmd;

  cfg_regs cfg_i
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_i(routed_cmd)
     ,.cmd_v_i(cfg_cmd_v)
     ,.cmd_ready_o(cfg_cmd_ready)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_ready_i(cfg_resp_ready)
     );

  clint_slice clint_i
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_i(routed_cmd)
     ,.cmd_v_i(clint_cmd_v)
     ,.cmd_ready_o(clint_cmd_ready)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.resp_ready_i(clint_resp_ready)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  resp_router resp_router_i
    (.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_ready_o(mem_resp_ready_o)
     ,.io_resp_i(io_resp_i)
     ,.io_resp_v_i(io_resp_v_i)
     ,.io_ready_o(io_resp_ready_o)
     ,.clint_resp_i(clint_resp)
     ,.clint_resp_v_i(clint_resp_v)
     ,.clint_ready_o(clint_resp_ready)
     ,.cfg_resp_i(cfg_resp)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_ready_o(cfg_resp_ready)
     ,.resp_o(routed_resp)
     ,.resp_v_o(resp_fifo_v)
     ,.fifo_ready_i(resp_fifo_ready)
     );

endmodule

`default_nettype wire

// ==== tb_softcore_uncore.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_softcore_uncore;

  localparam int timeout_lp = 300;

  // One expected response and the source that must receive it
  typedef struct packed
  {
    int                     src;
    logic                   chk;
    softcore_pkg::mem_msg_s msg;
  } exp_s;

  logic clk_i;
  logic arst_n_i;

  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] proc_cmd_i;
  logic [softcore_pkg::num_src_lp-1:0] proc_cmd_v_i;
  logic [softcore_pkg::num_src_lp-1:0] proc_cmd_ready_o;
  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] proc_resp_o;
  logic [softcore_pkg::num_src_lp-1:0] proc_resp_v_o;
  logic [softcore_pkg::num_src_lp-1:0] proc_resp_ready_i;

  softcore_pkg::mem_msg_s io_cmd_o, io_resp_i, mem_cmd_o, mem_resp_i;
  logic io_cmd_v_o, io_cmd_ready_i, io_resp_v_i, io_resp_ready_o;
  logic mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_ready_o;
  logic timer_irq_o, software_irq_o;

  exp_s exp_q [$];
  softcore_pkg::mem_msg_s mem_log_q [$];
  softcore_pkg::mem_msg_s io_log_q [$];
  softcore_pkg::mem_msg_s mem_pend_q [$];
  softcore_pkg::mem_msg_s io_pend_q [$];
  softcore_pkg::dword_t last_data [softcore_pkg::num_src_lp];
  logic [31:0] rng_state = 32'h7ba4_ab74;

  softcore_uncore dut_i
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.proc_cmd_i(proc_cmd_i)
     ,.proc_cmd_v_i(proc_cmd_v_i)
     ,.proc_cmd_ready_o(proc_cmd_ready_o)
     ,.proc_resp_o(proc_resp_o)
     ,.proc_resp_v_o(proc_resp_v_o)
     ,.proc_resp_ready_i(proc_resp_ready_i)
     ,.io_cmd_o(io_cmd_o)
     ,.io_cmd_v_o(io_cmd_v_o)
     ,.io_cmd_ready_i(io_cmd_ready_i)
     ,.io_resp_i(io_resp_i)
     ,.io_resp_v_i(io_resp_v_i)
     ,.io_resp_ready_o(io_resp_ready_o)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_o(mem_resp_ready_o)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Data that memory and host I/O return for a read
  function automatic softcore_pkg::dword_t ref_mem_data(input softcore_pkg::paddr_t addr);
    return softcore_pkg::dword_t'(addr) * 64'h9e37_79b9_7f4a_7c15;
  endfunction

  function automatic softcore_pkg::mem_msg_s build_cmd(input int src,
      input softcore_pkg::mem_msg_e kind, input softcore_pkg::paddr_t addr,
      input softcore_pkg::dword_t data);
    softcore_pkg::mem_msg_s cmd;
    cmd.msg_type = kind;
    cmd.addr     = addr;
    cmd.lce_id   = softcore_pkg::lce_id_t'(src);
    cmd.data     = data;
    return cmd;
  endfunction

  function automatic softcore_pkg::mem_msg_s make_resp(input softcore_pkg::mem_msg_s cmd);
    softcore_pkg::mem_msg_s resp;
    resp      = cmd;
    resp.data = (cmd.msg_type == softcore_pkg::e_mem_rd) ? ref_mem_data(cmd.addr) : '0;
    return resp;
  endfunction

  function automatic softcore_pkg::paddr_t rand_mem_addr();
    logic [63:0] r;
    r = {lcg_next(), lcg_next()};
    return softcore_pkg::dram_base_lp | {1'b0, r[38:3], 3'b000};
  endfunction

  function automatic softcore_pkg::paddr_t rand_io_addr();
    logic [31:0] r;
    r = lcg_next();
    return {16'h0000, softcore_pkg::host_dev_lp, r[19:3], 3'b000};
  endfunction

  function automatic softcore_pkg::paddr_t cfg_addr(input int sel);
    return {16'h0000, softcore_pkg::cfg_dev_lp, 15'h0000, softcore_pkg::cfg_sel_t'(sel),
            3'b000};
  endfunction

  function automatic softcore_pkg::paddr_t clint_addr(input softcore_pkg::clint_offset_t off);
    return {16'h0000, softcore_pkg::clint_dev_lp, 4'h0, off};
  endfunction

  task automatic report_failure(input string what);
    $display("TESTS FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check(input string name, input logic [127:0] exp_val,
                       input logic [127:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("ERROR %s expected %h got %h", name, exp_val, act_val);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Queues the expected response and holds valid until the FIFO takes it
  task automatic send_cmd(input int src, input softcore_pkg::mem_msg_s cmd,
                          input logic chk, input softcore_pkg::dword_t exp_data);
    exp_s e;
    int waited;
    e.src      = src;
    e.chk      = chk;
    e.msg      = cmd;
    e.msg.data = exp_data;
    exp_q.push_back(e);
    @(posedge clk_i);
    #1;
    proc_cmd_i[src]   = cmd;
    proc_cmd_v_i[src] = 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (!proc_cmd_ready_o[src] && waited < timeout_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (!proc_cmd_ready_o[src])
      report_failure("timeout waiting for proc_cmd_ready_o");
    @(posedge clk_i);
    #1;
    proc_cmd_v_i[src] = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < timeout_lp)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0)
      report_failure("timeout waiting for responses on proc_resp_o");
  endtask

  task automatic wait_timer_irq(input logic level);
    int waited;
    waited = 0;
    while (timer_irq_o !== level && waited < timeout_lp)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (timer_irq_o !== level)
      report_failure("timeout waiting for timer_irq_o to change");
  endtask

  task automatic transact(input int src, input softcore_pkg::mem_msg_e kind,
                          input softcore_pkg::paddr_t addr, input softcore_pkg::dword_t data,
                          input logic chk, input softcore_pkg::dword_t exp_data);
    send_cmd(src, build_cmd(src, kind, addr, data), chk, exp_data);
    wait_responses();
  endtask

  // One command to memory or host I/O checked at the target port and on return
  task automatic target_test(input int src, input logic to_io,
                             input softcore_pkg::mem_msg_e kind);
    softcore_pkg::paddr_t addr;
    softcore_pkg::mem_msg_s cmd;
    softcore_pkg::dword_t exp_data;
    addr     = to_io ? rand_io_addr() : rand_mem_addr();
    cmd      = build_cmd(src, kind, addr, {lcg_next(), lcg_next()});
    exp_data = (kind == softcore_pkg::e_mem_rd) ? ref_mem_data(addr) : '0;
    send_cmd(src, cmd, 1'b1, exp_data);
    wait_responses();
    if (to_io && io_log_q.size() == 1 && mem_log_q.size() == 0)
      check("io_cmd_o", 128'(cmd), 128'(io_log_q.pop_front()));
    else if (!to_io && mem_log_q.size() == 1 && io_log_q.size() == 0)
      check("mem_cmd_o", 128'(cmd), 128'(mem_log_q.pop_front()));
    else
      report_failure("command missing or misrouted between io_cmd_o and mem_cmd_o");
  endtask

  // Memory and host I/O targets with one response outstanding per queue head
  initial
  begin : target_responders
    logic mem_taken, io_taken;
    mem_resp_i   = '0;
    mem_resp_v_i = 1'b0;
    io_resp_i    = '0;
    io_resp_v_i  = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        mem_pend_q.push_back(mem_cmd_o);
        mem_log_q.push_back(mem_cmd_o);
      end
      if (io_cmd_v_o && io_cmd_ready_i)
      begin
        io_pend_q.push_back(io_cmd_o);
        io_log_q.push_back(io_cmd_o);
      end
      mem_taken = mem_resp_v_i && mem_resp_ready_o;
      io_taken  = io_resp_v_i && io_resp_ready_o;
      @(posedge clk_i);
      #1;
      if (mem_taken)
        mem_resp_v_i = 1'b0;
      if (!mem_resp_v_i && mem_pend_q.size() > 0)
      begin
        mem_resp_i   = make_resp(mem_pend_q.pop_front());
        mem_resp_v_i = 1'b1;
      end
      if (io_taken)
        io_resp_v_i = 1'b0;
      if (!io_resp_v_i && io_pend_q.size() > 0)
      begin
        io_resp_i   = make_resp(io_pend_q.pop_front());
        io_resp_v_i = 1'b1;
      end
    end
  end

  // Each response must match the oldest expected entry of its source
  initial
  begin : compare_responses
    exp_s e;
    int idx;
    forever
    begin
      @(negedge clk_i);
      for (int s = 0; s < softcore_pkg::num_src_lp; s++)
      begin
        if (proc_resp_v_o[s] && proc_resp_ready_i[s])
        begin
          idx = -1;
          for (int k = exp_q.size() - 1; k >= 0; k--)
            if (exp_q[k].src == s)
              idx = k;
          if (idx < 0)
            report_failure("response on proc_resp_o with no command outstanding");
          else
          begin
            e = exp_q[idx];
            exp_q.delete(idx);
            check("proc_resp_o.msg_type", 128'(e.msg.msg_type), 128'(proc_resp_o[s].msg_type));
            check("proc_resp_o.addr", 128'(e.msg.addr), 128'(proc_resp_o[s].addr));
            check("proc_resp_o.lce_id", 128'(e.msg.lce_id), 128'(proc_resp_o[s].lce_id));
            if (e.chk)
              check("proc_resp_o.data", 128'(e.msg.data), 128'(proc_resp_o[s].data));
            last_data[s] = proc_resp_o[s].data;
          end
        end
      end
    end
  end

  initial
  begin : stimulus
    softcore_pkg::mem_msg_s order_cmd [softcore_pkg::num_src_lp];
    softcore_pkg::mem_msg_s stall_cmd [4];
    softcore_pkg::mem_msg_s exp_first;
    softcore_pkg::dword_t cfg_model [softcore_pkg::cfg_regs_lp];
    softcore_pkg::dword_t mtime_first;
    arst_n_i          = 1'b0;
    proc_cmd_i        = '0;
    proc_cmd_v_i      = '0;
    proc_resp_ready_i = '1;
    io_cmd_ready_i    = 1'b1;
    mem_cmd_ready_i   = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check("proc_resp_v_o", 128'(0), 128'(proc_resp_v_o));
    check("mem_cmd_v_o", 128'(0), 128'(mem_cmd_v_o));
    check("io_cmd_v_o", 128'(0), 128'(io_cmd_v_o));
    check("timer_irq_o", 128'(0), 128'(timer_irq_o));
    check("software_irq_o", 128'(0), 128'(software_irq_o));
    check("proc_cmd_ready_o", 128'({softcore_pkg::num_src_lp{1'b1}}), 128'(proc_cmd_ready_o));

    for (int s = 0; s < softcore_pkg::num_src_lp; s++)
    begin
      repeat (3)
      begin
        target_test(s, 1'b0, softcore_pkg::e_mem_rd);
        target_test(s, 1'b0, softcore_pkg::e_mem_wr);
      end
      target_test(s, 1'b1, softcore_pkg::e_mem_rd);
      target_test(s, 1'b1, softcore_pkg::e_mem_wr);
    end

    // Config registers are written and read back from different sources
    for (int i = 0; i < softcore_pkg::cfg_regs_lp; i++)
    begin
      cfg_model[i] = {lcg_next(), lcg_next()};
      transact(i % 3, softcore_pkg::e_mem_wr, cfg_addr(i), cfg_model[i], 1'b1, '0);
    end
    for (int i = 0; i < softcore_pkg::cfg_regs_lp; i++)
      transact(2 - (i % 3), softcore_pkg::e_mem_rd, cfg_addr(i), '0, 1'b1, cfg_model[i]);

    transact(0, softcore_pkg::e_mem_wr, clint_addr(softcore_pkg::clint_msip_lp), 64'd1,
             1'b1, '0);
    check("software_irq_o", 128'(1), 128'(software_irq_o));
    transact(0, softcore_pkg::e_mem_wr, clint_addr(softcore_pkg::clint_msip_lp), '0, 1'b1, '0);
    check("software_irq_o", 128'(0), 128'(software_irq_o));
    transact(0, softcore_pkg::e_mem_wr, clint_addr(softcore_pkg::clint_mtimecmp_lp), '0,
             1'b1, '0);
    wait_timer_irq(1'b1);
    transact(0, softcore_pkg::e_mem_wr, clint_addr(softcore_pkg::clint_mtimecmp_lp), '1,
             1'b1, '0);
    wait_timer_irq(1'b0);
    transact(1, softcore_pkg::e_mem_rd, clint_addr(softcore_pkg::clint_mtimecmp_lp), '0,
             1'b1, '1);
    transact(1, softcore_pkg::e_mem_rd, clint_addr(softcore_pkg::clint_mtime_lp), '0, 1'b0, '0);
    mtime_first = last_data[1];
    transact(1, softcore_pkg::e_mem_rd, clint_addr(softcore_pkg::clint_mtime_lp), '0, 1'b0, '0);
    if (!(last_data[1] > mtime_first))
      report_failure("mtime did not increase between two reads");

    // All three sources wait behind a stalled memory port
    mem_cmd_ready_i = 1'b0;
    for (int s = 0; s < softcore_pkg::num_src_lp; s++)
    begin
      order_cmd[s] = build_cmd(s, softcore_pkg::e_mem_rd, rand_mem_addr(), '0);
      send_cmd(s, order_cmd[s], 1'b1, ref_mem_data(order_cmd[s].addr));
    end
    repeat (4) @(posedge clk_i);
    #1;
    check("mem_cmd_v_o", 128'(0), 128'(mem_cmd_v_o));
    mem_cmd_ready_i = 1'b1;
    wait_responses();
    if (mem_log_q.size() != 3)
      report_failure("memory commands lost after mem_cmd_ready_i rose");
    for (int k = 0; k < softcore_pkg::num_src_lp; k++)
      check("mem_cmd_o", 128'(order_cmd[2 - k]), 128'(mem_log_q.pop_front()));

    // LCE 1 holds its responses back
    proc_resp_ready_i[1] = 1'b0;
    for (int k = 0; k < 4; k++)
    begin
      stall_cmd[k] = build_cmd(1, softcore_pkg::e_mem_rd, rand_mem_addr(), '0);
      send_cmd(1, stall_cmd[k], 1'b1, ref_mem_data(stall_cmd[k].addr));
    end
    exp_first      = stall_cmd[0];
    exp_first.data = ref_mem_data(stall_cmd[0].addr);
    repeat (2)
    begin
      repeat (6) @(posedge clk_i);
      #1;
      check("proc_resp_v_o[1]", 128'(1), 128'(proc_resp_v_o[1]));
      check("proc_resp_o[1]", 128'(exp_first), 128'(proc_resp_o[1]));
    end
    proc_resp_ready_i[1] = 1'b1;
    wait_responses();
    if (mem_log_q.size() != 4)
      report_failure("memory commands lost under response back-pressure");
    for (int k = 0; k < 4; k++)
      check("mem_cmd_o", 128'(stall_cmd[k]), 128'(mem_log_q.pop_front()));

    repeat (2) @(posedge clk_i);
    if (exp_q.size() != 0 || io_log_q.size() != 0 || mem_log_q.size() != 0
        || dut_i.assertions_i.failures != 0)
    begin
      $display("TESTS FAILED");
      $fatal(1, "unmatched traffic or protocol assertion failures at end of run");
    end
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb_softcore_uncore_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_softcore_uncore_assertions
  (input  wire                                                   clk_i
   , input  wire                                                 arst_n_i
   , input  softcore_pkg::mem_msg_s                              io_cmd_o
   , input  wire                                                 io_cmd_v_o
   , input  wire                                                 io_cmd_ready_i
   , input  softcore_pkg::mem_msg_s                              mem_cmd_o
   , input  wire                                                 mem_cmd_v_o
   , input  wire                                                 mem_cmd_ready_i
   , input  softcore_pkg::mem_msg_s [softcore_pkg::num_src_lp-1:0] proc_resp_o
   , input  wire [softcore_pkg::num_src_lp-1:0]                  proc_resp_v_o
   , input  wire [softcore_pkg::num_src_lp-1:0]                  proc_resp_ready_i
   , input  wire                                                 timer_irq_o
   , input  wire                                                 software_irq_o
   );

  int failures = 0;

  io_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    io_cmd_v_o && !io_cmd_ready_i |=> io_cmd_v_o && $stable(io_cmd_o))
  else
  begin
    failures++;
    $error("io_cmd_o dropped or changed before io_cmd_ready_i");
  end

  mem_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
  else
  begin
    failures++;
    $error("mem_cmd_o dropped or changed before mem_cmd_ready_i");
  end

  for (genvar i = 0; i < softcore_pkg::num_src_lp; i++)
  begin : resp_hold
    resp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      proc_resp_v_o[i] && !proc_resp_ready_i[i]
        |=> proc_resp_v_o[i] && $stable(proc_resp_o[i]))
    else
    begin
      failures++;
      $error("proc_resp_o dropped or changed before proc_resp_ready_i");
    end
  end

  // A command goes to one target only
  one_target_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(io_cmd_v_o && mem_cmd_v_o))
  else
  begin
    failures++;
    $error("io_cmd_v_o and mem_cmd_v_o high together");
  end

  irq_reset_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !timer_irq_o && !software_irq_o)
  else
  begin
    failures++;
    $error("interrupt output high during reset");
  end

endmodule

bind softcore_uncore tb_softcore_uncore_assertions assertions_i
  (.clk_i(clk_i)
   ,.arst_n_i(arst_n_i)
   ,.io_cmd_o(io_cmd_o)
   ,.io_cmd_v_o(io_cmd_v_o)
   ,.io_cmd_ready_i(io_cmd_ready_i)
   ,.mem_cmd_o(mem_cmd_o)
   ,.mem_cmd_v_o(mem_cmd_v_o)
   ,.mem_cmd_ready_i(mem_cmd_ready_i)
   ,.proc_resp_o(proc_resp_o)
   ,.proc_resp_v_o(proc_resp_v_o)
   ,.proc_resp_ready_i(proc_resp_ready_i)
   ,.timer_irq_o(timer_irq_o)
   ,.software_irq_o(software_irq_o)
   );

`default_nettype wire
